/* Bender.yml */
package:
  name: opl3_slot_control

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/opl3_reg_pkg.sv
      - verilog/opl3_slot_pkg.sv
      - verilog/operator_reg_file.sv
      - verilog/channel_reg_file.sv
      - verilog/slot_sequencer.sv
      - verilog/opl3_slot_control.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/opl3_slot_control_assert.sv
      - verification/tb_opl3_slot_control.sv

/* filelist.f */
+incdir+include
verilog/opl3_reg_pkg.sv
verilog/opl3_slot_pkg.sv
verilog/operator_reg_file.sv
verilog/channel_reg_file.sv
verilog/slot_sequencer.sv
verilog/opl3_slot_control.sv
verification/opl3_slot_control_assert.sv
verification/tb_opl3_slot_control.sv

/* include/opl3_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPL3 slot control constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef OPL3_MACROS_SVH
`define OPL3_MACROS_SVH

// slot and channel geometry
`define OPL3_NUM_BANKS          2
`define OPL3_OPS_PER_BANK       18
`define OPL3_CHANNELS_PER_BANK  9
`define OPL3_OP_REG_DEPTH       22     // 0x00..0x15 with two gaps

// outstanding slot records toward the operator engine
`define OPL3_CREDITS            4

// per-operator register groups
`define OPL3_ADDR_AM_VIB        8'h20
`define OPL3_ADDR_KSL_TL        8'h40
`define OPL3_ADDR_AR_DR         8'h60
`define OPL3_ADDR_SL_RR         8'h80
`define OPL3_ADDR_WS            8'hE0

// per-channel register groups
`define OPL3_ADDR_FNUM_LO       8'hA0
`define OPL3_ADDR_KON_BLOCK     8'hB0
`define OPL3_ADDR_FB_CNT        8'hC0

// global registers
`define OPL3_ADDR_NTS           8'h08  // bank 0
`define OPL3_ADDR_RHYTHM        8'hBD  // bank 0
`define OPL3_ADDR_CONN_SEL      8'h04  // bank 1

`endif

/* verification/opl3_slot_control_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot control assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "opl3_macros.svh"

module opl3_slot_control_assert (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [2:0]                  credits,
    input  var opl3_slot_pkg::slot_rec_t slot_out,
    input  wire                        frame_done
);

    localparam opl3_slot_pkg::op_num_t LAST_OP = 5'(`OPL3_OPS_PER_BANK - 1);

    opl3_slot_pkg::bank_t   last_bank;
    opl3_slot_pkg::op_num_t last_op;
    opl3_slot_pkg::bank_t   next_bank;
    opl3_slot_pkg::op_num_t next_op;
    int unsigned            assert_failures;   // assertion failures seen so far

    initial assert_failures = 0;

    // last record seen, starts as if bank 1 slot 17 had just gone out
    always_ff @(posedge clk) begin
        if (rst) begin
            last_bank <= 1'b1;
            last_op   <= LAST_OP;
        end else if (slot_out.valid) begin
            last_bank <= slot_out.bank;
            last_op   <= slot_out.op_num;
        end
    end

    always_comb begin
        next_bank = (last_op == LAST_OP) ? !last_bank : last_bank;
        next_op   = (last_op == LAST_OP) ? '0 : last_op + 5'd1;
    end

    credits_bounded: assert property (@(posedge clk) disable iff (rst)
        credits <= `OPL3_CREDITS)
        else begin
            $error("credit counter above %0d", `OPL3_CREDITS);
            assert_failures++;
        end

    slot_in_order: assert property (@(posedge clk) disable iff (rst)
        slot_out.valid |-> slot_out.bank == next_bank && slot_out.op_num == next_op)
        else begin
            $error("slot record out of order");
            assert_failures++;
        end

    done_on_last_slot: assert property (@(posedge clk) disable iff (rst)
        frame_done == (slot_out.valid && slot_out.bank && slot_out.op_num == LAST_OP))
        else begin
            $error("frame_done not aligned with bank 1 slot 17");
            assert_failures++;
        end

endmodule

bind opl3_slot_control opl3_slot_control_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .credits    (u_seq.credits),
    .slot_out   (slot_out),
    .frame_done (frame_done)
);

`default_nettype wire

/* verification/tb_opl3_slot_control.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPL3 slot control testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "opl3_macros.svh"

module tb_opl3_slot_control;

    localparam int NUM_FRAMES   = 8;
    localparam int SETUP_CYCLES = NUM_FRAMES * 260 + 200;   // register loads and idle gaps
    localparam int MAX_CYCLES   = NUM_FRAMES * 36 * 8 + SETUP_CYCLES;
    localparam int STALL_CYCLES = 20;

    logic                      clk;
    logic                      rst;
    opl3_reg_pkg::reg_wr_t     reg_wr;
    logic                      sample_clk_en;
    logic                      credit_return;
    opl3_slot_pkg::slot_rec_t  slot_out;
    logic                      frame_done;

    // shadow of everything the host has written
    opl3_reg_pkg::reg_data_t   op_shadow [5][2][22];
    opl3_reg_pkg::reg_data_t   ch_shadow [3][2][9];
    logic                      nts_s;
    logic                      dam_s;
    logic                      dvb_s;
    logic                      ryt_s;
    opl3_reg_pkg::conn_sel_t   conn_s;

    logic                      armed;          // a frame has been started
    logic                      hold_off;       // engine keeps its credits
    int                        frame_records;
    int                        held;

    opl3_slot_control dut (
        .clk           (clk),
        .rst           (rst),
        .reg_wr        (reg_wr),
        .sample_clk_en (sample_clk_en),
        .credit_return (credit_return),
        .slot_out      (slot_out),
        .frame_done    (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_slot(input opl3_slot_pkg::slot_rec_t got,
                              input opl3_slot_pkg::slot_rec_t exp);
        if (got !== exp)
            report_failure($sformatf(
                "CHECK FAILED at %0t: slot_out bank %0d slot %0d got %h expected %h",
                $time, exp.bank, exp.op_num, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
    endtask

    function automatic opl3_reg_pkg::reg_addr_t op_base(input int g);
        case (g)
            0:       return `OPL3_ADDR_AM_VIB;
            1:       return `OPL3_ADDR_KSL_TL;
            2:       return `OPL3_ADDR_AR_DR;
            3:       return `OPL3_ADDR_SL_RR;
            default: return `OPL3_ADDR_WS;
        endcase
    endfunction

    function automatic opl3_reg_pkg::reg_addr_t ch_base(input int g);
        case (g)
            0:       return `OPL3_ADDR_FNUM_LO;
            1:       return `OPL3_ADDR_KON_BLOCK;
            default: return `OPL3_ADDR_FB_CNT;
        endcase
    endfunction

    // the record a slot should carry, built from the shadow registers
    function automatic opl3_slot_pkg::slot_rec_t expected_slot(input logic b, input int s);
        opl3_slot_pkg::slot_rec_t r;
        opl3_reg_pkg::reg_data_t  kb;
        opl3_reg_pkg::reg_data_t  c0;
        int                       loc;
        int                       ch;
        logic                     four_op;
        r          = '0;
        r.valid    = 1'b1;
        r.bank     = b;
        r.op_num   = opl3_slot_pkg::op_num_t'(s);
        loc        = (s / 6) * 8 + s % 6;   // groups of six, two unused addresses between
        {r.op_regs.am, r.op_regs.vib, r.op_regs.egt, r.op_regs.ksr, r.op_regs.mult} =
            op_shadow[0][b][loc];
        {r.op_regs.ksl, r.op_regs.tl} = op_shadow[1][b][loc];
        {r.op_regs.ar, r.op_regs.dr}  = op_shadow[2][b][loc];
        {r.op_regs.sl, r.op_regs.rr}  = op_shadow[3][b][loc];
        r.op_regs.ws = op_shadow[4][b][loc][2:0];

        four_op = conn_s[s % 3 + 3 * b];
        ch      = s % 3 + 3 * (s / 6);
        if (s >= 6 && s < 12 && four_op)
            ch = s % 3;                     // second pair half follows the first channel
        kb = ch_shadow[1][b][ch];
        c0 = ch_shadow[2][b][ch];
        r.ch_regs.fnum  = {kb[1:0], ch_shadow[0][b][ch]};
        r.ch_regs.block = kb[4:2];
        r.ch_regs.kon   = kb[5];
        r.ch_regs.fb    = c0[3:1];
        r.ch_regs.cnt0  = c0[0];
        r.ch_regs.cnt1  = (s >= 6 && s < 12) ? ch_shadow[2][b][3 + s % 3][0] : 1'b0;
        r.ch_regs.nts   = nts_s;
        r.ch_regs.dam   = dam_s;
        r.ch_regs.dvb   = dvb_s;

        r.op_type = opl3_slot_pkg::OP_NORMAL;
        if (!b && ryt_s) begin
            case (s)
                12, 15:  r.op_type = opl3_slot_pkg::OP_BASS_DRUM;
                13:      r.op_type = opl3_slot_pkg::OP_HI_HAT;
                14:      r.op_type = opl3_slot_pkg::OP_TOM_TOM;
                16:      r.op_type = opl3_slot_pkg::OP_SNARE_DRUM;
                17:      r.op_type = opl3_slot_pkg::OP_TOP_CYMBAL;
                default: r.op_type = opl3_slot_pkg::OP_NORMAL;
            endcase
        end

        case (s)
            0, 1, 2, 12: r.use_feedback = 1'b1;
            6, 7, 8:     r.use_feedback = !four_op;
            13, 14:      r.use_feedback = !(!b && ryt_s);
            default:     r.use_feedback = 1'b0;
        endcase
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic write_reg(input logic b, input opl3_reg_pkg::reg_addr_t a,
                             input opl3_reg_pkg::reg_data_t d);
        reg_wr.valid = 1'b1;
        reg_wr.bank  = b;
        reg_wr.addr  = a;
        reg_wr.data  = d;
        next_cycle();
        reg_wr = '0;
    endtask

    task automatic write_op(input int g, input logic b, input int loc,
                            input opl3_reg_pkg::reg_data_t d);
        op_shadow[g][b][loc] = d;
        write_reg(b, op_base(g) + opl3_reg_pkg::reg_addr_t'(loc), d);
    endtask

    task automatic write_ch(input int g, input logic b, input int c,
                            input opl3_reg_pkg::reg_data_t d);
        ch_shadow[g][b][c] = d;
        write_reg(b, ch_base(g) + opl3_reg_pkg::reg_addr_t'(c), d);
    endtask

    // gap locations get data too, a bad slot mapping would read it
    task automatic load_random_regs(input logic rhythm);
        opl3_reg_pkg::reg_data_t d;
        for (int g = 0; g < 5; g++)
            for (int b = 0; b < 2; b++)
                for (int loc = 0; loc < `OPL3_OP_REG_DEPTH; loc++)
                    write_op(g, b[0], loc, opl3_reg_pkg::reg_data_t'($urandom));
        for (int g = 0; g < 3; g++)
            for (int b = 0; b < 2; b++)
                for (int c = 0; c < `OPL3_CHANNELS_PER_BANK; c++)
                    write_ch(g, b[0], c, opl3_reg_pkg::reg_data_t'($urandom));
        d     = opl3_reg_pkg::reg_data_t'($urandom);
        nts_s = d[6];
        write_reg(1'b0, `OPL3_ADDR_NTS, d);
        d     = opl3_reg_pkg::reg_data_t'($urandom);
        d[5]  = rhythm;
        dam_s = d[7];
        dvb_s = d[6];
        ryt_s = d[5];
        write_reg(1'b0, `OPL3_ADDR_RHYTHM, d);
        d      = opl3_reg_pkg::reg_data_t'($urandom);
        conn_s = d[5:0];
        write_reg(1'b1, `OPL3_ADDR_CONN_SEL, d);
    endtask

    task automatic run_frame(input logic stall);
        frame_records = 0;
        if (stall) begin
            hold_off = 1'b1;
            next_cycle();
        end
        armed         = 1'b1;
        sample_clk_en = 1'b1;
        next_cycle();
        sample_clk_en = 1'b0;
        next_cycle();
        sample_clk_en = 1'b1;   // mid-frame pulse, must be ignored
        next_cycle();
        sample_clk_en = 1'b0;
        if (stall) begin
            repeat (STALL_CYCLES) next_cycle();
            if (frame_records != `OPL3_CREDITS)
                report_failure($sformatf(
                    "%0d records went out with no credit returned, limit is %0d",
                    frame_records, `OPL3_CREDITS));
            hold_off = 1'b0;
        end
        while (armed)
            next_cycle();
        repeat (4) next_cycle();  // a stray second frame would show here
    endtask

    // operator engine, gives credits back after a short random delay
    initial begin
        int delay;
        credit_return = 1'b0;
        held          = 0;
        delay         = 0;
        forever begin
            next_cycle();
            if (slot_out.valid === 1'b1)
                held++;
            if (held > `OPL3_CREDITS)
                report_failure("engine received more records than it had credits for");
            credit_return = 1'b0;
            if (delay > 0) begin
                delay--;
            end else if (held > 0 && !hold_off) begin
                credit_return = 1'b1;
                held--;
                delay = $urandom % 6;
            end
        end
    end

    // compare every record against the reference, in slot order
    initial begin
        logic exp_bank;
        int   exp_op;
        exp_bank = 1'b0;
        exp_op   = 0;
        @(posedge clk);
        forever begin
            @(negedge clk);
            check_bit("frame_done", frame_done,
                      slot_out.valid === 1'b1 && exp_bank && exp_op == 17);
            if (!armed)
                check_bit("slot_out.valid", slot_out.valid, 1'b0);
            if (slot_out.valid === 1'b1) begin
                check_slot(slot_out, expected_slot(exp_bank, exp_op));
                frame_records++;
                if (exp_op == `OPL3_OPS_PER_BANK - 1) begin
                    exp_op   = 0;
                    exp_bank = !exp_bank;
                end else begin
                    exp_op++;
                end
            end
            if (frame_done === 1'b1)
                armed = 1'b0;
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (dut.u_assert.assert_failures != 0)
                report_failure("a bound assertion on the DUT failed");
            if (cycles >= MAX_CYCLES)
                report_failure($sformatf("timeout after %0d cycles, frames did not complete",
                                         cycles));
        end
    end

    initial begin
        void'($urandom(32'hcfdc));
        rst           = 1'b1;
        reg_wr        = '0;
        sample_clk_en = 1'b0;
        armed         = 1'b0;
        hold_off      = 1'b0;
        frame_records = 0;
        nts_s         = 1'b0;
        dam_s         = 1'b0;
        dvb_s         = 1'b0;
        ryt_s         = 1'b0;
        conn_s        = '0;
        for (int g = 0; g < 5; g++)
            for (int b = 0; b < 2; b++)
                for (int i = 0; i < 22; i++)
                    op_shadow[g][b][i] = '0;
        for (int g = 0; g < 3; g++)
            for (int b = 0; b < 2; b++)
                for (int c = 0; c < 9; c++)
                    ch_shadow[g][b][c] = '0;

        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
        repeat (6) next_cycle();      // idle, outputs must stay low

        run_frame(1'b0);              // reset contents
        for (int f = 1; f < NUM_FRAMES; f++) begin
            load_random_regs(f[0]);   // rhythm on in odd frames
            run_frame(f == NUM_FRAMES - 1);
        end

        if (dut.u_assert.assert_failures != 0) begin
            report_failure("a bound assertion on the DUT failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog/channel_reg_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-channel and global registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "opl3_macros.svh"

module channel_reg_file (
    input  wire                         clk,
    input  wire                         rst,
    input  var opl3_reg_pkg::reg_wr_t   reg_wr,
    input  var opl3_slot_pkg::bank_t    slot_bank,
    input  var opl3_slot_pkg::op_num_t  slot_op,
    input  wire                         slot_issue,
    output opl3_slot_pkg::ch_regs_t     ch_regs,
    output logic                        ryt,
    output opl3_reg_pkg::conn_sel_t     conn_sel
);

    localparam int NUM_GROUPS = 3;
    localparam int G_FNUM     = 0;
    localparam int G_KB       = 1;
    localparam int G_FB       = 2;

    localparam opl3_reg_pkg::reg_addr_t GROUP_BASE [NUM_GROUPS] = '{
        `OPL3_ADDR_FNUM_LO,
        `OPL3_ADDR_KON_BLOCK,
        `OPL3_ADDR_FB_CNT
    };

    opl3_reg_pkg::reg_data_t ch_mem [NUM_GROUPS][`OPL3_NUM_BANKS][`OPL3_CHANNELS_PER_BANK];

    logic [NUM_GROUPS-1:0] grp_hit;
    logic [3:0] wr_idx;
    logic       nts;
    logic       dam;
    logic       dvb;

    logic [1:0] op_mod3;
    logic [1:0] op_div6;
    logic       mid_slot;    // slots 6..11, second half of a four-op pair
    logic [2:0] conn_idx;
    logic [3:0] base_ch;
    logic [3:0] freq_ch;
    logic [3:0] cnt1_ch;
    opl3_reg_pkg::reg_data_t fnum_lo_b;
    opl3_reg_pkg::reg_data_t kb_b;
    opl3_reg_pkg::reg_data_t fb_b;
    opl3_reg_pkg::reg_data_t cnt1_b;

    always_comb begin
        wr_idx = reg_wr.addr[3:0];
        for (int g = 0; g < NUM_GROUPS; g++) begin
            grp_hit[g] = reg_wr.valid && reg_wr.addr[7:4] == GROUP_BASE[g][7:4] &&
                         wr_idx < `OPL3_CHANNELS_PER_BANK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int g = 0; g < NUM_GROUPS; g++)
                for (int b = 0; b < `OPL3_NUM_BANKS; b++)
                    for (int c = 0; c < `OPL3_CHANNELS_PER_BANK; c++)
                        ch_mem[g][b][c] <= '0;
            nts      <= 1'b0;
            dam      <= 1'b0;
            dvb      <= 1'b0;
            ryt      <= 1'b0;
            conn_sel <= '0;
        end else begin
            for (int g = 0; g < NUM_GROUPS; g++)
                if (grp_hit[g])
                    ch_mem[g][reg_wr.bank][wr_idx] <= reg_wr.data;
            if (reg_wr.valid && !reg_wr.bank && reg_wr.addr == `OPL3_ADDR_NTS)
                nts <= reg_wr.data[6];
            if (reg_wr.valid && !reg_wr.bank && reg_wr.addr == `OPL3_ADDR_RHYTHM) begin
                dam <= reg_wr.data[7];
                dvb <= reg_wr.data[6];
                ryt <= reg_wr.data[5];  // drum key-on bits 4:0 not kept here
            end
            if (reg_wr.valid && reg_wr.bank && reg_wr.addr == `OPL3_ADDR_CONN_SEL)
                conn_sel <= reg_wr.data[5:0];
        end
    end

    // four-op pairs borrow frequency and feedback from the lower channel
    always_comb begin
        op_mod3   = 2'(slot_op % 5'd3);
        op_div6   = 2'(slot_op / 5'd6);
        mid_slot  = slot_op >= 5'd6 && slot_op < 5'd12;
        conn_idx  = 3'(op_mod3) + (slot_bank ? 3'd3 : 3'd0);
        base_ch   = 4'(op_mod3) + 4'(op_div6) * 4'd3;
        freq_ch   = (mid_slot && conn_sel[conn_idx]) ? 4'(op_mod3) : base_ch;
        cnt1_ch   = 4'd3 + 4'(op_mod3);
        fnum_lo_b = ch_mem[G_FNUM][slot_bank][freq_ch];
        kb_b      = ch_mem[G_KB][slot_bank][freq_ch];
        fb_b      = ch_mem[G_FB][slot_bank][freq_ch];
        cnt1_b    = ch_mem[G_FB][slot_bank][cnt1_ch];
    end

    always_ff @(posedge clk) begin
        if (slot_issue) begin
            ch_regs.fnum  <= {kb_b[1:0], fnum_lo_b};
            ch_regs.block <= kb_b[4:2];
            ch_regs.kon   <= kb_b[5];
            ch_regs.fb    <= fb_b[3:1];
            ch_regs.cnt0  <= fb_b[0];
            ch_regs.cnt1  <= mid_slot && cnt1_b[0];
            ch_regs.nts   <= nts;
            ch_regs.dam   <= dam;
            ch_regs.dvb   <= dvb;
        end
    end

endmodule

`default_nettype wire

/* verilog/operator_reg_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-operator register banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "opl3_macros.svh"

module operator_reg_file (
    input  wire                         clk,
    input  wire                         rst,
    input  var opl3_reg_pkg::reg_wr_t   reg_wr,
    input  var opl3_slot_pkg::bank_t    slot_bank,
    input  var opl3_slot_pkg::op_num_t  slot_op,
    input  wire                         slot_issue,
    output opl3_slot_pkg::op_regs_t     op_regs
);

    localparam int NUM_GROUPS = 5;
    localparam int G_AVEKM    = 0;
    localparam int G_KSL_TL   = 1;
    localparam int G_AR_DR    = 2;
    localparam int G_SL_RR    = 3;
    localparam int G_WS       = 4;

    localparam opl3_reg_pkg::reg_addr_t GROUP_BASE [NUM_GROUPS] = '{
        `OPL3_ADDR_AM_VIB,
        `OPL3_ADDR_KSL_TL,
        `OPL3_ADDR_AR_DR,
        `OPL3_ADDR_SL_RR,
        `OPL3_ADDR_WS
    };

    opl3_reg_pkg::reg_data_t op_mem [NUM_GROUPS][`OPL3_NUM_BANKS][`OPL3_OP_REG_DEPTH];

    logic [NUM_GROUPS-1:0] grp_hit;
    logic [4:0]            wr_idx;
    logic [4:0]            rd_idx;
    logic [4:0]            op_div6;

    // every group starts on a 32-byte boundary, so the low bits are the slot offset
    always_comb begin
        wr_idx = reg_wr.addr[4:0];
        for (int g = 0; g < NUM_GROUPS; g++) begin
            grp_hit[g] = reg_wr.valid && reg_wr.addr[7:5] == GROUP_BASE[g][7:5] &&
                         wr_idx < `OPL3_OP_REG_DEPTH;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int g = 0; g < NUM_GROUPS; g++)
                for (int b = 0; b < `OPL3_NUM_BANKS; b++)
                    for (int i = 0; i < `OPL3_OP_REG_DEPTH; i++)
                        op_mem[g][b][i] <= '0;
        end else begin
            for (int g = 0; g < NUM_GROUPS; g++)
                if (grp_hit[g])
                    op_mem[g][reg_wr.bank][wr_idx] <= reg_wr.data;
        end
    end

    // slots 0-5 -> 0x00, 6-11 -> 0x08, 12-17 -> 0x10
    always_comb begin
        op_div6 = slot_op / 5'd6;
        rd_idx  = slot_op + (op_div6 << 1);
    end

    always_ff @(posedge clk) begin
        if (slot_issue) begin
            {op_regs.am, op_regs.vib, op_regs.egt, op_regs.ksr, op_regs.mult} <=
                op_mem[G_AVEKM][slot_bank][rd_idx];
            {op_regs.ksl, op_regs.tl} <= op_mem[G_KSL_TL][slot_bank][rd_idx];
            {op_regs.ar, op_regs.dr}  <= op_mem[G_AR_DR][slot_bank][rd_idx];
            {op_regs.sl, op_regs.rr}  <= op_mem[G_SL_RR][slot_bank][rd_idx];
            op_regs.ws <= op_mem[G_WS][slot_bank][rd_idx][2:0];  // upper bits unused
        end
    end

endmodule

`default_nettype wire

/* verilog/opl3_reg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPL3 register bus and field types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package opl3_reg_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // host write, no handshake
    typedef struct packed {
        logic      valid;
        logic      bank;
        reg_addr_t addr;
        reg_data_t data;
    } reg_wr_t;

    // operator fields
    typedef logic [3:0] mult_t;      // frequency multiplier
    typedef logic [1:0] ksl_t;       // key scale level
    typedef logic [5:0] tl_t;        // total level
    typedef logic [3:0] env_rate_t;  // ar, dr, sl, rr
    typedef logic [2:0] ws_t;        // waveform select

    // channel fields
    typedef logic [9:0] fnum_t;
    typedef logic [2:0] block_t;     // octave
    typedef logic [2:0] fb_t;        // self-feedback depth

    // one four-op enable per channel pair, bank 0 in bits 2:0
    typedef logic [5:0] conn_sel_t;

endpackage

`default_nettype wire

/* verilog/opl3_slot_control.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPL3 slot control top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module opl3_slot_control (
    input  wire                        clk,
    input  wire                        rst,
    input  var opl3_reg_pkg::reg_wr_t  reg_wr,
    input  wire                        sample_clk_en,
    input  wire                        credit_return,
    output opl3_slot_pkg::slot_rec_t   slot_out,
    output logic                       frame_done
);

    opl3_slot_pkg::bank_t    slot_bank;
    opl3_slot_pkg::op_num_t  slot_op;
    logic                    slot_issue;
    logic                    ryt;
    opl3_reg_pkg::conn_sel_t conn_sel;
    logic                    rec_valid;
    opl3_slot_pkg::bank_t    rec_bank;
    opl3_slot_pkg::op_num_t  rec_op;
    opl3_slot_pkg::op_type_t rec_type;
    logic                    rec_feedback;
    opl3_slot_pkg::op_regs_t op_regs;
    opl3_slot_pkg::ch_regs_t ch_regs;

    slot_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .sample_clk_en (sample_clk_en),
        .credit_return (credit_return),
        .ryt           (ryt),
        .conn_sel      (conn_sel),
        .slot_bank     (slot_bank),
        .slot_op       (slot_op),
        .slot_issue    (slot_issue),
        .rec_valid     (rec_valid),
        .rec_bank      (rec_bank),
        .rec_op        (rec_op),
        .rec_type      (rec_type),
        .rec_feedback  (rec_feedback),
        .frame_done    (frame_done)
    );

    operator_reg_file u_op_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .slot_bank  (slot_bank),
        .slot_op    (slot_op),
        .slot_issue (slot_issue),
        .op_regs    (op_regs)
    );

    channel_reg_file u_ch_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .slot_bank  (slot_bank),
        .slot_op    (slot_op),
        .slot_issue (slot_issue),
        .ch_regs    (ch_regs),
        .ryt        (ryt),
        .conn_sel   (conn_sel)
    );

    // all parts registered on the same issue cycle
    always_comb begin
        slot_out.valid        = rec_valid;
        slot_out.bank         = rec_bank;
        slot_out.op_num       = rec_op;
        slot_out.op_type      = rec_type;
        slot_out.use_feedback = rec_feedback;
        slot_out.op_regs      = op_regs;
        slot_out.ch_regs      = ch_regs;
    end

endmodule

`default_nettype wire

/* verilog/opl3_slot_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPL3 slot record types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package opl3_slot_pkg;

    typedef logic       bank_t;
    typedef logic [4:0] op_num_t;    // 0..17 within a bank

    typedef enum logic [2:0] {
        OP_NORMAL,
        OP_BASS_DRUM,
        OP_HI_HAT,
        OP_TOM_TOM,
        OP_SNARE_DRUM,
        OP_TOP_CYMBAL
    } op_type_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

    typedef struct packed {
        logic                    am;
        logic                    vib;
        logic                    egt;
        logic                    ksr;
        opl3_reg_pkg::mult_t     mult;
        opl3_reg_pkg::ksl_t      ksl;
        opl3_reg_pkg::tl_t       tl;
        opl3_reg_pkg::env_rate_t ar;
        opl3_reg_pkg::env_rate_t dr;
        opl3_reg_pkg::env_rate_t sl;
        opl3_reg_pkg::env_rate_t rr;
        opl3_reg_pkg::ws_t       ws;
    } op_regs_t;

    typedef struct packed {
        opl3_reg_pkg::fnum_t  fnum;
        opl3_reg_pkg::block_t block;
        logic                 kon;
        opl3_reg_pkg::fb_t    fb;
        logic                 cnt0;
        logic                 cnt1;      // second connection bit, four-op pairs only
        logic                 nts;
        logic                 dam;
        logic                 dvb;
    } ch_regs_t;

    typedef struct packed {
        logic     valid;
        bank_t    bank;
        op_num_t  op_num;
        op_type_t op_type;
        logic     use_feedback;
        op_regs_t op_regs;
        ch_regs_t ch_regs;
    } slot_rec_t;

endpackage

`default_nettype wire

/* verilog/slot_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot sequencer with engine credits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "opl3_macros.svh"

module slot_sequencer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          sample_clk_en,
    input  wire                          credit_return,
    input  wire                          ryt,
    input  var opl3_reg_pkg::conn_sel_t  conn_sel,
    output opl3_slot_pkg::bank_t         slot_bank,
    output opl3_slot_pkg::op_num_t       slot_op,
    output logic                         slot_issue,
    output logic                         rec_valid,
    output opl3_slot_pkg::bank_t         rec_bank,
    output opl3_slot_pkg::op_num_t       rec_op,
    output opl3_slot_pkg::op_type_t      rec_type,
    output logic                         rec_feedback,
    output logic                         frame_done
);

    localparam int CREDIT_W = $clog2(`OPL3_CREDITS + 1);
    localparam opl3_slot_pkg::op_num_t LAST_OP = 5'(`OPL3_OPS_PER_BANK - 1);

    opl3_slot_pkg::seq_state_t state;
    opl3_slot_pkg::bank_t      cur_bank;
    opl3_slot_pkg::op_num_t    cur_op;
    logic [CREDIT_W-1:0]       credits;
    logic                      last_slot;
    logic [2:0]                fb_idx;
    opl3_slot_pkg::op_type_t   type_c;
    logic                      feedback_c;

    always_comb begin
        slot_issue = state == opl3_slot_pkg::SEQ_RUN && credits != '0;
        slot_bank  = cur_bank;
        slot_op    = cur_op;
        last_slot  = cur_bank && cur_op == LAST_OP;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= opl3_slot_pkg::SEQ_IDLE;
            cur_bank <= 1'b0;
            cur_op   <= '0;
        end else begin
            case (state)
                opl3_slot_pkg::SEQ_IDLE: if (sample_clk_en) state <= opl3_slot_pkg::SEQ_RUN;
                opl3_slot_pkg::SEQ_RUN:  if (slot_issue && last_slot) state <= opl3_slot_pkg::SEQ_IDLE;
                default:                 state <= opl3_slot_pkg::SEQ_IDLE;
            endcase
            if (slot_issue) begin
                if (cur_op == LAST_OP) begin   // wraps to bank 0 slot 0 after the frame
                    cur_op   <= '0;
                    cur_bank <= !cur_bank;
                end else begin
                    cur_op <= cur_op + 5'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            credits <= CREDIT_W'(`OPL3_CREDITS);
        else if (slot_issue && !credit_return)
            credits <= credits - 1'b1;
        else if (!slot_issue && credit_return)
            credits <= credits + 1'b1;
    end

    // rhythm voices only exist in bank 0
    always_comb begin
        type_c = opl3_slot_pkg::OP_NORMAL;
        if (!cur_bank && ryt) begin
            case (cur_op)
                5'd12, 5'd15: type_c = opl3_slot_pkg::OP_BASS_DRUM;
                5'd13:        type_c = opl3_slot_pkg::OP_HI_HAT;
                5'd14:        type_c = opl3_slot_pkg::OP_TOM_TOM;
                5'd16:        type_c = opl3_slot_pkg::OP_SNARE_DRUM;
                5'd17:        type_c = opl3_slot_pkg::OP_TOP_CYMBAL;
                default:      type_c = opl3_slot_pkg::OP_NORMAL;
            endcase
        end
    end

    always_comb begin
        fb_idx = 3'(cur_op - 5'd6) + (cur_bank ? 3'd3 : 3'd0);
        case (cur_op)
            5'd0, 5'd1, 5'd2, 5'd12: feedback_c = 1'b1;
            5'd6, 5'd7, 5'd8:        feedback_c = !conn_sel[fb_idx];  // off in four-op mode
            5'd13, 5'd14:            feedback_c = !(!cur_bank && ryt);
            default:                 feedback_c = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rec_valid  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            rec_valid  <= slot_issue;
            frame_done <= slot_issue && last_slot;
        end
    end

    always_ff @(posedge clk) begin
        if (slot_issue) begin
            rec_bank     <= cur_bank;
            rec_op       <= cur_op;
            rec_type     <= type_c;
            rec_feedback <= feedback_c;
        end
    end

endmodule

`default_nettype wire
